// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := lsu_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
hw/lsu_pkg.sv
hw/lsu_lane_decode.sv
hw/lsu_load_extract.sv
hw/lsu_wait_timer.sv
hw/lsu_control.sv
hw/lsu_data_ram.sv
hw/lsu_top.sv
testbench/lsu_tb.sv

// ==== hw/lsu_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_control import lsu_pkg::*;
(
    input  wire     clk,
    input  wire     rst_n,
    input  wire     req,
    input  wire     is_load,
    input  wire     is_store,
    input  wire     illegal,
    input  wire     misaligned,
    input  wire     timer_expired,
    output logic    load_request,
    output logic    busy,
    output logic    timer_start,
    output logic    ram_read,
    output logic    ram_write,
    output logic    capture,
    output logic    done,
    output logic    fault
);

    lsu_state_t state;
    lsu_state_t state_next;
    logic       pending;
    logic       access_entry;
    logic       refused;

    assign refused      = illegal | misaligned;
    assign busy         = pending | (state != ST_IDLE);
    assign load_request = req & ~busy;

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
            begin
                // Request fields are registered, decode is valid now
                if (pending)
                begin
                    if (refused)
                    begin
                        state_next = ST_FINISH;
                    end
                    else
                    begin
                        state_next = ST_ACCESS;
                    end
                end
            end
            ST_ACCESS:
            begin
                if (timer_expired)
                begin
                    state_next = ST_FINISH;
                end
            end
            default:
                state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state        <= ST_IDLE;
            pending      <= 1'b0;
            access_entry <= 1'b0;
        end
        else
        begin
            state        <= state_next;
            pending      <= load_request;
            access_entry <= (state == ST_IDLE) && pending && !refused;
        end
    end

    ////////////////////
    // Outputs
    ////////////////////

    assign timer_start = access_entry;
    assign ram_read    = (state == ST_ACCESS) & timer_expired & is_load;
    assign ram_write   = (state == ST_ACCESS) & timer_expired & is_store;

    // load_data settles on the edge that closes the done cycle
    assign done    = (state == ST_FINISH);
    assign fault   = done & refused;
    assign capture = done & is_load & ~refused;

    ////////////////////
    // Checks
    ////////////////////

    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done);

    assert property (@(posedge clk) disable iff (!rst_n) fault |-> done);

    assert property (@(posedge clk) disable iff (!rst_n) !(ram_read && ram_write));

    // Timer and FSM together give the fixed latency
    assert property (@(posedge clk) disable iff (!rst_n)
        timer_start |-> ##(LSU_LATENCY - 1) (done && !fault));

endmodule

`default_nettype wire

// ==== hw/lsu_data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_data_ram import lsu_pkg::*;
(
    input  wire                 clk,
    input  wire                 ram_read,
    input  wire                 ram_write,
    input  wire ram_addr_t      word_index,
    input  wire byte_mask_t     byte_mask,
    input  wire word_t          lane_data,
    output word_t               read_word
);

    word_t mem [RAM_DEPTH];

    // Byte lane writes
    always_ff @(posedge clk)
    begin
        if (ram_write)
        begin
            for (int lane = 0; lane < 4; lane++)
            begin
                if (byte_mask[lane])
                begin
                    mem[word_index][8*lane +: 8] <= lane_data[8*lane +: 8];
                end
            end
        end
    end

    // Registered read port
    always_ff @(posedge clk)
    begin
        if (ram_read)
        begin
            read_word <= mem[word_index];
        end
    end

endmodule

`default_nettype wire

// ==== hw/lsu_lane_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_lane_decode import lsu_pkg::*;
(
    input  wire opcode_t    opcode,
    input  wire funct3_t    funct3,
    input  wire word_t      address,
    input  wire word_t      store_data,
    output logic            is_load,
    output logic            is_store,
    output logic            illegal,
    output logic            misaligned,
    output byte_mask_t      byte_mask,
    output word_t           lane_data,
    output ram_addr_t       word_index
);

    logic [1:0] offset;

    assign offset     = address[1:0];
    assign word_index = address[RAM_ADDR_BITS+1:2];

    assign is_load  = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);

    // Legal width codes per opcode
    always_comb
    begin
        illegal = 1'b0;
        if (!is_load && !is_store)
        begin
            illegal = 1'b1;
        end
        else
        begin
            case (funct3)
                F3_BYTE, F3_HALF, F3_WORD:
                    illegal = 1'b0;
                F3_BYTE_U, F3_HALF_U:
                    illegal = is_store;
                default:
                    illegal = 1'b1;
            endcase
        end
    end

    ////////////////////
    // Lane mask and store steering
    ////////////////////

    always_comb
    begin
        misaligned = 1'b0;
        byte_mask  = 4'b0000;
        lane_data  = store_data;
        case (funct3)
            F3_BYTE, F3_BYTE_U:
            begin
                byte_mask = 4'b0001 << offset;
                lane_data = {4{store_data[7:0]}};
            end
            F3_HALF, F3_HALF_U:
            begin
                misaligned = offset[0];
                byte_mask  = 4'b0011 << {offset[1], 1'b0};
                lane_data  = {2{store_data[15:0]}};
            end
            F3_WORD:
            begin
                misaligned = (offset != 2'b00);
                byte_mask  = 4'b1111;
            end
            default:
                byte_mask = 4'b0000;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/lsu_load_extract.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_load_extract import lsu_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             capture,
    input  wire funct3_t    funct3,
    input  wire [1:0]       byte_offset,
    input  wire word_t      read_word,
    output word_t           load_data
);

    word_t shifted;
    word_t extended;

    // Addressed byte or halfword down to bit 0
    assign shifted = read_word >> {byte_offset, 3'b000};

    always_comb
    begin
        case (funct3)
            F3_BYTE:
                extended = {{24{shifted[7]}}, shifted[7:0]};
            F3_BYTE_U:
                extended = {24'b0, shifted[7:0]};
            F3_HALF:
                extended = {{16{shifted[15]}}, shifted[15:0]};
            F3_HALF_U:
                extended = {16'b0, shifted[15:0]};
            default:
                extended = shifted;
        endcase
    end

    // Held until the next load completes
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            load_data <= '0;
        end
        else if (capture)
        begin
            load_data <= extended;
        end
    end

endmodule

`default_nettype wire

// ==== hw/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    ////////////////////
    // Widths
    ////////////////////

    // Data and address words
    typedef logic [31:0] word_t;

    typedef logic [6:0] opcode_t;

    // Access width code
    typedef logic [2:0] funct3_t;

    // One bit per byte lane, bit k is byte offset k
    typedef logic [3:0] byte_mask_t;

    localparam int RAM_ADDR_BITS = 8;
    localparam int RAM_DEPTH     = 256;

    // Word index into the data RAM
    typedef logic [RAM_ADDR_BITS-1:0] ram_addr_t;

    ////////////////////
    // Encodings
    ////////////////////

    localparam opcode_t OPC_LOAD  = 7'b00_000_11;
    localparam opcode_t OPC_STORE = 7'b01_000_11;

    localparam funct3_t F3_BYTE   = 3'b000;
    localparam funct3_t F3_HALF   = 3'b001;
    localparam funct3_t F3_WORD   = 3'b010;
    localparam funct3_t F3_BYTE_U = 3'b100;
    localparam funct3_t F3_HALF_U = 3'b101;

    ////////////////////
    // Timing
    ////////////////////

    // Wait states of the RAM port
    localparam int MEM_WAIT_CYCLES = 2;

    // Acceptance edge to done
    localparam int LSU_LATENCY = MEM_WAIT_CYCLES + 2;

    localparam int WAIT_CNT_BITS = $clog2(MEM_WAIT_CYCLES + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_FINISH
    } lsu_state_t;

endpackage

`default_nettype wire

// ==== hw/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             req,
    input  wire opcode_t    opcode,
    input  wire funct3_t    funct3,
    input  wire word_t      address,
    input  wire word_t      store_data,
    output logic            busy,
    output logic            done,
    output logic            fault,
    output word_t           load_data
);

    opcode_t    opcode_q;
    funct3_t    funct3_q;
    word_t      address_q;
    word_t      store_data_q;

    logic       load_request;
    logic       is_load;
    logic       is_store;
    logic       illegal;
    logic       misaligned;
    byte_mask_t byte_mask;
    word_t      lane_data;
    ram_addr_t  word_index;
    logic       timer_start;
    logic       timer_expired;
    logic       ram_read;
    logic       ram_write;
    logic       capture;
    word_t      read_word;

    ////////////////////
    // Request register
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (load_request)
        begin
            opcode_q     <= opcode;
            funct3_q     <= funct3;
            address_q    <= address;
            store_data_q <= store_data;
        end
    end

    lsu_control u_lsu_control (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .is_load       (is_load),
        .is_store      (is_store),
        .illegal       (illegal),
        .misaligned    (misaligned),
        .timer_expired (timer_expired),
        .load_request  (load_request),
        .busy          (busy),
        .timer_start   (timer_start),
        .ram_read      (ram_read),
        .ram_write     (ram_write),
        .capture       (capture),
        .done          (done),
        .fault         (fault)
    );

    lsu_wait_timer u_lsu_wait_timer (
        .clk           (clk),
        .rst_n         (rst_n),
        .timer_start   (timer_start),
        .timer_expired (timer_expired)
    );

    lsu_lane_decode u_lsu_lane_decode (
        .opcode        (opcode_q),
        .funct3        (funct3_q),
        .address       (address_q),
        .store_data    (store_data_q),
        .is_load       (is_load),
        .is_store      (is_store),
        .illegal       (illegal),
        .misaligned    (misaligned),
        .byte_mask     (byte_mask),
        .lane_data     (lane_data),
        .word_index    (word_index)
    );

    lsu_data_ram u_lsu_data_ram (
        .clk           (clk),
        .ram_read      (ram_read),
        .ram_write     (ram_write),
        .word_index    (word_index),
        .byte_mask     (byte_mask),
        .lane_data     (lane_data),
        .read_word     (read_word)
    );

    lsu_load_extract u_lsu_load_extract (
        .clk           (clk),
        .rst_n         (rst_n),
        .capture       (capture),
        .funct3        (funct3_q),
        .byte_offset   (address_q[1:0]),
        .read_word     (read_word),
        .load_data     (load_data)
    );

endmodule

`default_nettype wire

// ==== hw/lsu_wait_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_wait_timer import lsu_pkg::*;
(
    input  wire     clk,
    input  wire     rst_n,
    input  wire     timer_start,
    output logic    timer_expired
);

    logic [WAIT_CNT_BITS-1:0] count;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= '0;
        end
        else if (timer_start)
        begin
            count <= WAIT_CNT_BITS'(MEM_WAIT_CYCLES);
        end
        else if (count != '0)
        begin
            count <= count - 1'b1;
        end
    end

    // Last wait state, the RAM port acts here
    assign timer_expired = (count == WAIT_CNT_BITS'(1));

    assert property (@(posedge clk) disable iff (!rst_n) timer_start |-> (count == '0));

endmodule

`default_nettype wire

// ==== testbench/lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb import lsu_pkg::*;
();

    localparam int CLK_PERIOD         = 8;
    localparam int RESET_CYCLES       = 10;
    localparam int RANDOM_REQUESTS    = 400;
    // About 1050 requests, a legal one occupies 6 cycles from drive to next drive
    localparam int REQUEST_BUDGET     = 1100;
    localparam int CYCLES_PER_REQUEST = 6;
    localparam int MAX_CYCLES = REQUEST_BUDGET * CYCLES_PER_REQUEST + RESET_CYCLES + 200;

    logic       clk;
    logic       rst_n;
    logic       req;
    opcode_t    opcode;
    funct3_t    funct3;
    word_t      address;
    word_t      store_data;
    logic       busy;
    logic       done;
    logic       fault;
    word_t      load_data;

    word_t      shadow_mem [RAM_DEPTH];
    logic       exp_fault_q [$];
    logic       exp_capture_q [$];
    word_t      exp_data_q [$];
    word_t      model_load_data;
    logic       outstanding;
    int         accept_cycle;
    int         cycle_count;
    int         done_count;

    lsu_top u_lsu_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .opcode     (opcode),
        .funct3     (funct3),
        .address    (address),
        .store_data (store_data),
        .busy       (busy),
        .done       (done),
        .fault      (fault),
        .load_data  (load_data)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    // Returns the fault bit, exp_data is the extended load value
    function automatic logic reference_access(input opcode_t opc, input funct3_t f3,
                                              input word_t addr, input word_t mem_word,
                                              output word_t exp_data);
        logic       bad;
        int         base;
        logic [7:0] byte_val;
        logic [15:0] half_val;
        bad      = 1'b0;
        exp_data = '0;
        base     = 8 * int'(addr[1:0]);
        if (opc != OPC_LOAD && opc != OPC_STORE)
            bad = 1'b1;
        else if (f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7)
            bad = 1'b1;
        else if (opc == OPC_STORE && (f3 == F3_BYTE_U || f3 == F3_HALF_U))
            bad = 1'b1;
        else if ((f3 == F3_HALF || f3 == F3_HALF_U) && addr[0])
            bad = 1'b1;
        else if (f3 == F3_WORD && addr[1:0] != 2'b00)
            bad = 1'b1;
        if (!bad && opc == OPC_LOAD)
        begin
            case (f3)
                F3_BYTE, F3_BYTE_U:
                begin
                    byte_val = mem_word[base +: 8];
                    exp_data = (f3 == F3_BYTE) ? 32'($signed(byte_val)) : 32'(byte_val);
                end
                F3_HALF, F3_HALF_U:
                begin
                    half_val = mem_word[base +: 16];
                    exp_data = (f3 == F3_HALF) ? 32'($signed(half_val)) : 32'(half_val);
                end
                default:
                    exp_data = mem_word;
            endcase
        end
        return bad;
    endfunction

    function automatic word_t merge_store(input word_t old_word, input funct3_t f3,
                                          input logic [1:0] offset, input word_t data);
        word_t merged;
        int    base;
        merged = old_word;
        base   = 8 * int'(offset);
        case (f3)
            F3_BYTE: merged[base +: 8]  = data[7:0];
            F3_HALF: merged[base +: 16] = data[15:0];
            default: merged = data;
        endcase
        return merged;
    endfunction

    function automatic word_t fill_pattern(input int idx);
        return 32'h9e37_79b9 * (idx + 1) ^ {4{8'(idx)}};
    endfunction

    function automatic word_t random_upper_bits();
        return $urandom() & 32'hffff_fc00;
    endfunction

    ////////////////////
    // Request driver
    ////////////////////

    // Called 1 ns after a rising edge with the DUT idle
    task automatic issue_request(input opcode_t opc, input funct3_t f3, input word_t addr,
                                 input word_t wdata, input bit poke_busy);
        int    idx;
        int    target;
        int    k;
        logic  exp_fault;
        word_t exp_data;
        idx       = int'(addr[9:2]);
        exp_fault = reference_access(opc, f3, addr, shadow_mem[idx], exp_data);
        exp_fault_q.push_back(exp_fault);
        exp_capture_q.push_back(!exp_fault && opc == OPC_LOAD);
        exp_data_q.push_back(exp_data);
        if (!exp_fault && opc == OPC_STORE)
            shadow_mem[idx] = merge_store(shadow_mem[idx], f3, addr[1:0], wdata);
        target     = done_count + 1;
        req        = 1'b1;
        opcode     = opc;
        funct3     = f3;
        address    = addr;
        store_data = wdata;
        @(posedge clk);
        #1;
        req = 1'b0;
        // Requests while busy must be dropped
        if (poke_busy)
        begin
            for (k = 0; k < 3; k++)
            begin
                req        = 1'b1;
                opcode     = OPC_STORE;
                funct3     = F3_WORD;
                store_data = ~wdata;
                @(posedge clk);
                #1;
            end
            req = 1'b0;
        end
        while (done_count < target)
        begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic store_word(input word_t addr, input word_t data);
        issue_request(OPC_STORE, F3_WORD, addr, data, 1'b0);
    endtask

    task automatic load_word(input word_t addr);
        issue_request(OPC_LOAD, F3_WORD, addr, '0, 1'b0);
    endtask

    ////////////////////
    // Checks
    ////////////////////

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
            stop_with_failure();
        end
    end

    always @(negedge clk)
    begin : compare_responses
        logic  exp_fault;
        logic  exp_capture;
        word_t exp_data;
        int    latency;
        int    exp_latency;
        if (rst_n)
        begin
            assert (busy === outstanding)
            else
            begin
                $display("ERROR t=%0t busy: got %b expected %b", $time, busy, outstanding);
                stop_with_failure();
            end
            assert (load_data === model_load_data)
            else
            begin
                $display("ERROR t=%0t load_data: got %h expected %h",
                         $time, load_data, model_load_data);
                stop_with_failure();
            end
            assert (done === 1'b1 || fault === 1'b0)
            else
            begin
                $display("ERROR t=%0t fault: got %b expected 0", $time, fault);
                stop_with_failure();
            end
            if (req && !busy)
            begin
                accept_cycle = cycle_count + 1;
                outstanding  = 1'b1;
            end
            if (done === 1'b1)
            begin
                assert (exp_fault_q.size() != 0)
                else
                begin
                    $display("Done pulse at t=%0t with no request outstanding", $time);
                    stop_with_failure();
                end
                exp_fault   = exp_fault_q.pop_front();
                exp_capture = exp_capture_q.pop_front();
                exp_data    = exp_data_q.pop_front();
                latency     = cycle_count - accept_cycle;
                exp_latency = exp_fault ? 1 : LSU_LATENCY;
                assert (fault === exp_fault)
                else
                begin
                    $display("ERROR t=%0t fault: got %b expected %b", $time, fault, exp_fault);
                    stop_with_failure();
                end
                assert (latency == exp_latency)
                else
                begin
                    $display("ERROR t=%0t done latency: got %0d expected %0d",
                             $time, latency, exp_latency);
                    stop_with_failure();
                end
                if (exp_capture)
                    model_load_data = exp_data;
                outstanding = 1'b0;
                done_count  = done_count + 1;
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial
    begin : run_tests
        int      idx;
        int      off;
        int      i;
        word_t   data;
        opcode_t opc;
        word_t   patterns [4];
        rst_n           = 1'b0;
        req             = 1'b0;
        opcode          = '0;
        funct3          = '0;
        address         = '0;
        store_data      = '0;
        model_load_data = '0;
        outstanding     = 1'b0;
        accept_cycle    = 0;
        cycle_count     = 0;
        done_count      = 0;
        patterns        = '{32'hf08c_a5b7, 32'h7f31_4a05, 32'h8000_807f, 32'h017f_ff80};
        void'($urandom(32'hd053_804c));
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        // Word round trip over the whole RAM
        for (idx = 0; idx < RAM_DEPTH; idx++)
            store_word(random_upper_bits() | (idx << 2), fill_pattern(idx));
        for (idx = 0; idx < RAM_DEPTH; idx++)
            load_word(random_upper_bits() | (idx << 2));

        // Partial stores touch only their lanes
        for (idx = 20; idx < 24; idx++)
        begin
            for (off = 0; off < 4; off++)
            begin
                issue_request(OPC_STORE, F3_BYTE, (idx << 2) | off, $urandom(), 1'b0);
                load_word(idx << 2);
            end
            for (off = 0; off < 4; off += 2)
            begin
                issue_request(OPC_STORE, F3_HALF, (idx << 2) | off, $urandom(), 1'b0);
                load_word(idx << 2);
            end
        end

        // Sign and zero extension
        for (i = 0; i < 4; i++)
        begin
            idx = 40 + i;
            store_word(idx << 2, patterns[i]);
            for (off = 0; off < 4; off++)
            begin
                issue_request(OPC_LOAD, F3_BYTE, (idx << 2) | off, '0, 1'b0);
                issue_request(OPC_LOAD, F3_BYTE_U, (idx << 2) | off, '0, 1'b0);
            end
            for (off = 0; off < 4; off += 2)
            begin
                issue_request(OPC_LOAD, F3_HALF, (idx << 2) | off, '0, 1'b0);
                issue_request(OPC_LOAD, F3_HALF_U, (idx << 2) | off, '0, 1'b0);
            end
        end

        // Refused accesses
        idx = 50;
        issue_request(OPC_LOAD, F3_BYTE, (idx << 2) | 3, '0, 1'b0);
        for (off = 1; off < 4; off++)
        begin
            issue_request(OPC_LOAD, F3_WORD, (idx << 2) | off, '0, 1'b0);
            issue_request(OPC_STORE, F3_WORD, (idx << 2) | off, 32'hdead_beef, 1'b0);
        end
        for (off = 1; off < 4; off += 2)
        begin
            issue_request(OPC_LOAD, F3_HALF, (idx << 2) | off, '0, 1'b0);
            issue_request(OPC_STORE, F3_HALF, (idx << 2) | off, 32'hdead_beef, 1'b0);
        end
        issue_request(7'b0010011, F3_WORD, idx << 2, 32'h1234_5678, 1'b0);
        issue_request(7'b0110011, F3_WORD, idx << 2, 32'h1234_5678, 1'b0);
        issue_request(7'b1100011, F3_WORD, idx << 2, 32'h1234_5678, 1'b0);
        for (i = 3; i < 8; i++)
        begin
            if (i == 3 || i > 5)
                issue_request(OPC_LOAD, funct3_t'(i), idx << 2, '0, 1'b0);
            issue_request(OPC_STORE, funct3_t'(i), idx << 2, 32'h0bad_f00d, 1'b0);
        end
        load_word(idx << 2);

        // Requests during busy are ignored
        issue_request(OPC_LOAD, F3_WORD, 60 << 2, '0, 1'b1);
        issue_request(OPC_STORE, F3_WORD, 61 << 2, 32'h5a5a_c3c3, 1'b1);
        load_word(60 << 2);
        load_word(61 << 2);

        // Random mix over 16 words
        for (i = 0; i < RANDOM_REQUESTS; i++)
        begin
            case ($urandom() % 8)
                0, 1, 2: opc = OPC_LOAD;
                3, 4, 5: opc = OPC_STORE;
                6:       opc = 7'b0010011;
                default: opc = 7'($urandom());
            endcase
            idx  = $urandom() % 16;
            off  = $urandom() % 4;
            data = $urandom();
            issue_request(opc, funct3_t'($urandom()), random_upper_bits() | (idx << 2) | off,
                          data, 1'b0);
        end

        repeat (4) @(posedge clk);
        if (exp_fault_q.size() == 0)
        begin
            $display("NO ERRORS");
            $finish;
        end
        else
        begin
            $display("%0d requests never completed with done", exp_fault_q.size());
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire
